// File: sim.f
design/lqm_pkg.sv
design/lqm_sdp_ram.sv
design/blk_free_pool.sv
design/que_state_table.sv
design/enq_ctrl.sv
design/deq_ctrl.sv
design/lqm_top.sv
bench/lqm_asserts.sv
bench/lqm_tb.sv

// File: Bender.yml
package:
  name: lqm

sources:
  # queue manager RTL, package first
  - design/lqm_pkg.sv
  - design/lqm_sdp_ram.sv
  - design/blk_free_pool.sv
  - design/que_state_table.sv
  - design/enq_ctrl.sv
  - design/deq_ctrl.sv
  - design/lqm_top.sv
  # testbench and bound assertions
  - target: simulation
    files:
      - bench/lqm_asserts.sv
      - bench/lqm_tb.sv

// File: bench/lqm_tb.sv
// testbench for the queue manager; random traffic checked against per-queue FIFO models
`timescale 1ns/1ps
`default_nettype none

module lqm_tb;

    import lqm_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 3;
    localparam int STIM_CYCLES  = 2000;
    localparam int PHASE_LEN    = 250;
    // drain needs at most 64 dequeues plus one empty probe per queue and the rest is margin
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 1000;
    localparam int FIFO_DEP     = BLK_N * SUB_DEP;

    // one cycle of user-side stimulus
    typedef struct packed {
        logic  enq_vld;
        qid_t  enq_qid;
        data_t enq_data;
        logic  deq_vld;
        qid_t  deq_qid;
    } stim_t;

    logic                 clk;
    logic                 rst_n;
    logic                 enq_vld;
    qid_t                 enq_qid;
    data_t                enq_data;
    logic                 deq_vld;
    qid_t                 deq_qid;
    que_cnt_t [QUE_N-1:0] drop_th;
    logic                 enq_drop;
    logic                 out_vld;
    data_t                out_data;

    integer seed;
    int     cycle_cnt;
    int     mismatch_cnt;
    int     other_cnt;
    int     accepted_cnt;
    int     th_drop_cnt;
    int     pool_drop_cnt;
    int     same_q_cnt;
    stim_t  stim;
    logic   fill_phase;

    // reference model holds one circular FIFO per queue indexed by the running totals
    data_t model_mem [QUE_N][FIFO_DEP];
    int    wr_tot    [QUE_N];
    int    rd_tot    [QUE_N];

    lqm_top dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_enq_vld  (enq_vld),
        .i_enq_qid  (enq_qid),
        .i_enq_data (enq_data),
        .i_deq_vld  (deq_vld),
        .i_deq_qid  (deq_qid),
        .i_drop_th  (drop_th),
        .o_enq_drop (enq_drop),
        .o_deq_vld  (out_vld),
        .o_deq_data (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // a block is taken at each write with sub-position zero, given back after the last read
    function automatic int free_blocks();
        int held;
        held = 0;
        for (int q = 0; q < QUE_N; q++) begin
            held += (wr_tot[q] + SUB_DEP - 1) / SUB_DEP - rd_tot[q] / SUB_DEP;
        end
        return BLK_N - held;
    endfunction

    // drive one cycle, predict from the model, then check the outputs after the edge
    task automatic run_cycle(input stim_t s);
        int    qe;
        int    qd;
        logic  exp_drop;
        logic  exp_vld;
        data_t exp_data;
        qe       = int'(s.enq_qid);
        qd       = int'(s.deq_qid);
        enq_vld  = s.enq_vld;
        enq_qid  = s.enq_qid;
        enq_data = s.enq_data;
        deq_vld  = s.deq_vld;
        deq_qid  = s.deq_qid;

        exp_drop = 1'b0;
        if (s.enq_vld) begin
            if (wr_tot[qe] - rd_tot[qe] >= int'(drop_th[qe])) begin
                exp_drop = 1'b1;
                th_drop_cnt++;
            end else if ((wr_tot[qe] % SUB_DEP == 0) && (free_blocks() == 0)) begin
                exp_drop = 1'b1;
                pool_drop_cnt++;
            end
        end
        exp_vld  = s.deq_vld && (wr_tot[qd] != rd_tot[qd]);
        exp_data = model_mem[qd][rd_tot[qd] % FIFO_DEP];

        // both decisions above saw the state before the edge
        if (exp_vld) begin
            rd_tot[qd]++;
        end
        if (s.enq_vld && !exp_drop) begin
            model_mem[qe][wr_tot[qe] % FIFO_DEP] = s.enq_data;
            wr_tot[qe]++;
            accepted_cnt++;
        end

        @(posedge clk);
        #DRIVE_DLY;
        assert (enq_drop === exp_drop) else begin
            mismatch_cnt++;
            $display("MISMATCH o_enq_drop: got %h, expected %h (queue %h)",
                     enq_drop, exp_drop, qe);
        end
        assert (out_vld === exp_vld) else begin
            mismatch_cnt++;
            $display("MISMATCH o_deq_vld: got %h, expected %h (queue %h)",
                     out_vld, exp_vld, qd);
        end
        if (exp_vld) begin
            assert (out_data === exp_data) else begin
                mismatch_cnt++;
                $display("MISMATCH o_deq_data: got %h, expected %h (queue %h)",
                         out_data, exp_data, qd);
            end
        end
    endtask

    // watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + 1);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        seed          = 18142;
        mismatch_cnt  = 0;
        other_cnt     = 0;
        accepted_cnt  = 0;
        th_drop_cnt   = 0;
        pool_drop_cnt = 0;
        same_q_cnt    = 0;
        rst_n         = 1'b0;
        stim          = '0;
        enq_vld       = 1'b0;
        enq_qid       = '0;
        enq_data      = '0;
        deq_vld       = 1'b0;
        deq_qid       = '0;
        for (int q = 0; q < QUE_N; q++) begin
            drop_th[q] = que_cnt_t'(1 + rand_below(40));
            wr_tot[q]  = 0;
            rd_tot[q]  = 0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        assert ((enq_drop === 1'b0) && (out_vld === 1'b0)) else begin
            other_cnt++;
            $display("outputs are not low after reset");
        end

        // alternate fill and empty phases so the pool runs dry and recovers
        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            fill_phase     = ((cyc / PHASE_LEN) % 2) == 0;
            stim.enq_vld   = rand_below(100) < (fill_phase ? 75 : 35);
            stim.deq_vld   = rand_below(100) < (fill_phase ? 35 : 75);
            stim.enq_qid   = qid_t'(rand_below(QUE_N));
            stim.enq_data  = data_t'(rand_below(65536));
            if (rand_below(100) < 40) begin
                stim.deq_qid = stim.enq_qid;
            end else begin
                stim.deq_qid = qid_t'(rand_below(QUE_N));
            end
            if (stim.enq_vld && stim.deq_vld && (stim.enq_qid == stim.deq_qid)) begin
                same_q_cnt++;
            end
            run_cycle(stim);
        end

        // drain every queue, then probe each one once more while empty
        stim = '0;
        stim.deq_vld = 1'b1;
        for (int q = 0; q < QUE_N; q++) begin
            stim.deq_qid = qid_t'(q);
            while (wr_tot[q] != rd_tot[q]) begin
                run_cycle(stim);
            end
            run_cycle(stim);
        end

        assert (pool_drop_cnt > 0) else begin
            other_cnt++;
            $display("stimulus never exhausted the block pool");
        end
        assert (th_drop_cnt > 0) else begin
            other_cnt++;
            $display("no enqueue ever reached its queue threshold");
        end

        $display("traffic: %0d accepted, %0d threshold drops, %0d pool drops",
                 accepted_cnt, th_drop_cnt, pool_drop_cnt);
        $display("traffic: %0d same-queue cycles", same_q_cnt);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if ((mismatch_cnt == 0) && (other_cnt == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/lqm_asserts.sv
// protocol assertions for the queue manager top level, attached by bind
`timescale 1ns/1ps
`default_nettype none

module lqm_asserts (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_deq_vld,
    input logic i_alloc,
    input logic i_release,
    input logic i_enq_drop,
    input logic i_deq_out_vld
);

    import lqm_pkg::*;

    // blocks the pool should still hold, kept from its alloc and release strobes
    int free_cnt;

    // a release lands at the edge, so it counts from the next cycle on
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            free_cnt <= BLK_N;
        end else begin
            free_cnt <= free_cnt - int'(i_alloc) + int'(i_release);
        end
    end

    // both output strobes come out of reset low
    a_reset_quiet: assert property (@(posedge i_clk)
        !i_rst_n |=> (!i_enq_drop && !i_deq_out_vld))
        else $error("output strobe high right after reset");

    // the pool never hands out a block it does not have
    a_alloc_nonempty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_alloc |-> (free_cnt > 0))
        else $error("block allocated while the pool is empty");

    // every dequeue output answers a dequeue strobe one cycle earlier
    a_deq_follows_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_deq_out_vld |-> $past(i_deq_vld))
        else $error("o_deq_vld without a preceding dequeue strobe");

endmodule

bind lqm_top lqm_asserts u_asserts (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_deq_vld     (i_deq_vld),
    .i_alloc       (alloc),
    .i_release     (release_blk),
    .i_enq_drop    (o_enq_drop),
    .i_deq_out_vld (o_deq_vld)
);

`default_nettype wire

// File: design/lqm_top.sv
// top level of the linked-list queue manager; connects state table, control paths, pool and RAMs
`timescale 1ns/1ps
`default_nettype none

module lqm_top (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_enq_vld,
    input  lqm_pkg::qid_t                          i_enq_qid,
    input  lqm_pkg::data_t                         i_enq_data,
    input  logic                                   i_deq_vld,
    input  lqm_pkg::qid_t                          i_deq_qid,
    input  lqm_pkg::que_cnt_t [lqm_pkg::QUE_N-1:0] i_drop_th,
    output logic                                   o_enq_drop,
    output logic                                   o_deq_vld,
    output lqm_pkg::data_t                         o_deq_data
);

    import lqm_pkg::*;

    que_state_t enq_state;
    que_state_t deq_state;
    enq_upd_t   enq_upd;
    deq_upd_t   deq_upd;

    // pool handshake
    logic      pool_nonempty;
    blk_addr_t free_blk;
    logic      alloc;
    logic      release_blk;
    blk_addr_t rel_blk;

    // data RAM, written by enqueue, read by dequeue
    logic      dmem_we;
    mem_addr_t dmem_waddr;
    data_t     dmem_wdata;
    mem_addr_t dmem_raddr;
    data_t     dmem_rdata;

    // link RAM, same split of ports
    logic      lmem_we;
    blk_addr_t lmem_waddr;
    blk_addr_t lmem_wdata;
    blk_addr_t lmem_raddr;
    blk_addr_t lmem_rdata;

    que_state_table u_state (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_enq_qid   (i_enq_qid),
        .o_enq_state (enq_state),
        .i_deq_qid   (i_deq_qid),
        .o_deq_state (deq_state),
        .i_enq_upd   (enq_upd),
        .i_deq_upd   (deq_upd)
    );

    enq_ctrl u_enq (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_enq_vld       (i_enq_vld),
        .i_enq_qid       (i_enq_qid),
        .i_enq_data      (i_enq_data),
        .i_drop_th       (i_drop_th),
        .i_state         (enq_state),
        .i_pool_nonempty (pool_nonempty),
        .i_free_blk      (free_blk),
        .o_alloc         (alloc),
        .o_enq_upd       (enq_upd),
        .o_dmem_we       (dmem_we),
        .o_dmem_waddr    (dmem_waddr),
        .o_dmem_wdata    (dmem_wdata),
        .o_lmem_we       (lmem_we),
        .o_lmem_waddr    (lmem_waddr),
        .o_lmem_wdata    (lmem_wdata),
        .o_enq_drop      (o_enq_drop)
    );

    deq_ctrl u_deq (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_deq_vld    (i_deq_vld),
        .i_deq_qid    (i_deq_qid),
        .i_state      (deq_state),
        .o_dmem_raddr (dmem_raddr),
        .i_dmem_rdata (dmem_rdata),
        .o_lmem_raddr (lmem_raddr),
        .i_lmem_rdata (lmem_rdata),
        .o_deq_upd    (deq_upd),
        .o_release    (release_blk),
        .o_rel_blk    (rel_blk),
        .o_deq_vld    (o_deq_vld),
        .o_deq_data   (o_deq_data)
    );

    blk_free_pool u_pool (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_alloc    (alloc),
        .o_nonempty (pool_nonempty),
        .o_free_blk (free_blk),
        .i_release  (release_blk),
        .i_rel_blk  (rel_blk)
    );

    lqm_sdp_ram #(
        .payload_t (data_t),
        .DEPTH     (BLK_N * SUB_DEP)
    ) u_dmem (
        .i_clk   (i_clk),
        .i_we    (dmem_we),
        .i_waddr (dmem_waddr),
        .i_wdata (dmem_wdata),
        .i_raddr (dmem_raddr),
        .o_rdata (dmem_rdata)
    );

    lqm_sdp_ram #(
        .payload_t (blk_addr_t),
        .DEPTH     (BLK_N)
    ) u_lmem (
        .i_clk   (i_clk),
        .i_we    (lmem_we),
        .i_waddr (lmem_waddr),
        .i_wdata (lmem_wdata),
        .i_raddr (lmem_raddr),
        .o_rdata (lmem_rdata)
    );

endmodule

`default_nettype wire

// File: design/deq_ctrl.sv
// dequeue path; reads the head entry, releases drained blocks and registers the output
`timescale 1ns/1ps
`default_nettype none

module deq_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_deq_vld,
    input  lqm_pkg::qid_t       i_deq_qid,
    input  lqm_pkg::que_state_t i_state,
    output lqm_pkg::mem_addr_t  o_dmem_raddr,
    input  lqm_pkg::data_t      i_dmem_rdata,
    output lqm_pkg::blk_addr_t  o_lmem_raddr,
    input  lqm_pkg::blk_addr_t  i_lmem_rdata,
    output lqm_pkg::deq_upd_t   o_deq_upd,
    output logic                o_release,
    output lqm_pkg::blk_addr_t  o_rel_blk,
    output logic                o_deq_vld,
    output lqm_pkg::data_t      o_deq_data
);

    import lqm_pkg::*;

    logic deq_ok;

    // dequeue of an empty queue is ignored
    assign deq_ok = i_deq_vld && (i_state.cnt != '0);

    assign o_dmem_raddr = {i_state.head, i_state.rsub};

    // link of the head block gives the next head once this block drains
    assign o_lmem_raddr = i_state.head;

    assign o_release = deq_ok && (i_state.rsub == SUB_LAST);
    assign o_rel_blk = i_state.head;

    assign o_deq_upd = '{vld: deq_ok, qid: i_deq_qid, rel: o_release, nxt_head: i_lmem_rdata};

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_deq_vld <= 1'b0;
        end else begin
            o_deq_vld <= deq_ok;
        end
    end

    // data register holds its value between dequeues
    always_ff @(posedge i_clk) begin
        if (deq_ok) begin
            o_deq_data <= i_dmem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: design/enq_ctrl.sv
// enqueue admission; drives state update, block allocation, data and link writes, drop strobe
`timescale 1ns/1ps
`default_nettype none

module enq_ctrl (
    input  logic                                     i_clk,
    input  logic                                     i_rst_n,
    input  logic                                     i_enq_vld,
    input  lqm_pkg::qid_t                            i_enq_qid,
    input  lqm_pkg::data_t                           i_enq_data,
    input  lqm_pkg::que_cnt_t [lqm_pkg::QUE_N-1:0]   i_drop_th,
    input  lqm_pkg::que_state_t                      i_state,
    input  logic                                     i_pool_nonempty,
    input  lqm_pkg::blk_addr_t                       i_free_blk,
    output logic                                     o_alloc,
    output lqm_pkg::enq_upd_t                        o_enq_upd,
    output logic                                     o_dmem_we,
    output lqm_pkg::mem_addr_t                       o_dmem_waddr,
    output lqm_pkg::data_t                           o_dmem_wdata,
    output logic                                     o_lmem_we,
    output lqm_pkg::blk_addr_t                       o_lmem_waddr,
    output lqm_pkg::blk_addr_t                       o_lmem_wdata,
    output logic                                     o_enq_drop
);

    import lqm_pkg::*;

    logic      need_blk;
    logic      accept;
    blk_addr_t wr_blk;

    // write pointer at zero means the tail block is full or there is none
    assign need_blk = (i_state.wsub == '0);

    assign accept = i_enq_vld &&
                    (i_state.cnt < i_drop_th[i_enq_qid]) &&
                    !(need_blk && !i_pool_nonempty);

    assign o_alloc = accept && need_blk;
    assign wr_blk  = need_blk ? i_free_blk : i_state.tail;

    assign o_enq_upd = '{vld: accept, qid: i_enq_qid, alloc: o_alloc, blk: i_free_blk};

    assign o_dmem_we    = accept;
    assign o_dmem_waddr = {wr_blk, i_state.wsub};
    assign o_dmem_wdata = i_enq_data;

    // chain the new block behind the old tail
    assign o_lmem_we    = o_alloc && (i_state.bcnt != '0);
    assign o_lmem_waddr = i_state.tail;
    assign o_lmem_wdata = i_free_blk;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_enq_drop <= 1'b0;
        end else begin
            o_enq_drop <= i_enq_vld && !accept;
        end
    end

endmodule

`default_nettype wire

// File: design/que_state_table.sv
// per-queue state registers with two indexed read ports and merged enqueue/dequeue updates
`timescale 1ns/1ps
`default_nettype none

module que_state_table (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  lqm_pkg::qid_t       i_enq_qid,
    output lqm_pkg::que_state_t o_enq_state,
    input  lqm_pkg::qid_t       i_deq_qid,
    output lqm_pkg::que_state_t o_deq_state,
    input  lqm_pkg::enq_upd_t   i_enq_upd,
    input  lqm_pkg::deq_upd_t   i_deq_upd
);

    import lqm_pkg::*;

    que_state_t st     [QUE_N];
    que_state_t st_nxt [QUE_N];

    // reads see the state before the edge
    assign o_enq_state = st[i_enq_qid];
    assign o_deq_state = st[i_deq_qid];

    for (genvar q = 0; q < QUE_N; q++) begin : g_que
        logic enq_hit;
        logic deq_hit;
        logic enq_alloc;
        logic deq_rel;
        logic head_from_alloc;

        assign enq_hit   = i_enq_upd.vld && (i_enq_upd.qid == qid_t'(q));
        assign deq_hit   = i_deq_upd.vld && (i_deq_upd.qid == qid_t'(q));
        assign enq_alloc = enq_hit && i_enq_upd.alloc;
        assign deq_rel   = deq_hit && i_deq_upd.rel;

        // new block becomes head when the queue had no block, or its only
        // block leaves in this same cycle
        assign head_from_alloc = enq_alloc &&
            ((st[q].bcnt == '0) || (deq_rel && (st[q].bcnt == blk_cnt_t'(1))));

        always_comb begin
            st_nxt[q] = st[q];

            st_nxt[q].cnt  = st[q].cnt + que_cnt_t'(enq_hit) - que_cnt_t'(deq_hit);
            st_nxt[q].bcnt = st[q].bcnt + blk_cnt_t'(enq_alloc) - blk_cnt_t'(deq_rel);

            if (enq_hit) begin
                st_nxt[q].wsub = (st[q].wsub == SUB_LAST) ? '0 : st[q].wsub + 1'b1;
            end
            if (deq_hit) begin
                st_nxt[q].rsub = (st[q].rsub == SUB_LAST) ? '0 : st[q].rsub + 1'b1;
            end

            if (enq_alloc) begin
                st_nxt[q].tail = i_enq_upd.blk;
            end

            if (head_from_alloc) begin
                st_nxt[q].head = i_enq_upd.blk;
            end else if (deq_rel) begin
                st_nxt[q].head = i_deq_upd.nxt_head;
            end
        end

        always_ff @(posedge i_clk) begin
            if (!i_rst_n) begin
                st[q] <= '0;
            end else begin
                st[q] <= st_nxt[q];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/blk_free_pool.sv
// free-block bitmap; hands out the lowest free block and takes released blocks back
`timescale 1ns/1ps
`default_nettype none

module blk_free_pool (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_alloc,
    output logic               o_nonempty,
    output lqm_pkg::blk_addr_t o_free_blk,
    input  logic               i_release,
    input  lqm_pkg::blk_addr_t i_rel_blk
);

    import lqm_pkg::*;

    // one bit per block that is set while the block is free
    logic [BLK_N-1:0] free_map;

    assign o_nonempty = |free_map;

    // priority encoder, lowest index wins
    always_comb begin
        o_free_blk = '0;
        for (int i = BLK_N - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                o_free_blk = blk_addr_t'(i);
            end
        end
    end

    // allocated and released blocks are never the same one
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            free_map <= '1;
        end else begin
            if (i_alloc) begin
                free_map[o_free_blk] <= 1'b0;
            end
            if (i_release) begin
                free_map[i_rel_blk] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/lqm_sdp_ram.sv
// simple dual-port register array; one write port and one combinational read port
`timescale 1ns/1ps
`default_nettype none

module lqm_sdp_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic                     i_clk,
    input  logic                     i_we,
    input  logic [$clog2(DEPTH)-1:0] i_waddr,
    input  payload_t                 i_wdata,
    input  logic [$clog2(DEPTH)-1:0] i_raddr,
    output payload_t                 o_rdata
);

    payload_t mem [DEPTH];

    // write lands at the edge, so a same-cycle read still sees the old word
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata = mem[i_raddr];

endmodule

`default_nettype wire

// File: design/lqm_pkg.sv
// shared sizes, types and update structs for the queue manager; imported by every RTL block
`default_nettype none

package lqm_pkg;

    // queue and buffer geometry
    localparam int QUE_N   = 8;
    localparam int QUE_W   = 3;
    localparam int BLK_N   = 16;
    localparam int BLK_AW  = 4;
    localparam int SUB_DEP = 4;
    localparam int SUB_AW  = 2;
    localparam int MEM_AW  = 6;
    localparam int DATA_W  = 16;
    localparam int CNT_W   = 7;
    localparam int BCNT_W  = 5;

    typedef logic [QUE_W-1:0]  qid_t;
    typedef logic [BLK_AW-1:0] blk_addr_t;
    typedef logic [SUB_AW-1:0] sub_addr_t;
    // block address in the upper bits, sub-position in the lower bits
    typedef logic [MEM_AW-1:0] mem_addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [CNT_W-1:0]  que_cnt_t;
    typedef logic [BCNT_W-1:0] blk_cnt_t;

    // last sub-position of a block, where the pointers wrap
    localparam sub_addr_t SUB_LAST = sub_addr_t'(SUB_DEP - 1);

    // state of one queue
    typedef struct packed {
        que_cnt_t  cnt;
        blk_cnt_t  bcnt;
        blk_addr_t head;
        blk_addr_t tail;
        sub_addr_t wsub;
        sub_addr_t rsub;
    } que_state_t;

    // accepted enqueue with alloc set when a fresh block was taken from the pool
    typedef struct packed {
        logic      vld;
        qid_t      qid;
        logic      alloc;
        blk_addr_t blk;
    } enq_upd_t;

    // performed dequeue with rel set when the head block leaves the queue
    typedef struct packed {
        logic      vld;
        qid_t      qid;
        logic      rel;
        blk_addr_t nxt_head;
    } deq_upd_t;

endpackage

`default_nettype wire
